//--- mesh_collector.sv
`timescale 1ns/1ns
`include "mesh_defines.svh"

module mesh_collector (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  mesh_link_if.rx                 link_i,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic [`MESH_X_W-1:0]    resp_x_o,
  output logic [`MESH_ADDR_W-1:0] resp_addr_o,
  output logic [`MESH_DATA_W-1:0] resp_data_o,
  output logic [`MESH_CNT_W-1:0]  drop_count_o
);
  import mesh_pkg::*;

  logic                   is_resp;
  logic                   accept;
  logic                   drop_q;
  logic [`MESH_CNT_W-1:0] drop_cnt_q;

  assign is_resp = (link_i.op == OP_RESP);

  // requests here overshot the row, always taken
  assign link_i.ready = !is_resp || !resp_valid_o || resp_ready_i;
  assign accept       = link_i.valid && link_i.ready;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_valid_o <= 1'b0;
      drop_q       <= 1'b0;
      drop_cnt_q   <= '0;
    end
    else
    begin
      if (accept && is_resp)
        resp_valid_o <= 1'b1;
      else if (resp_ready_i)
        resp_valid_o <= 1'b0;
      drop_q     <= accept && !is_resp;
      drop_cnt_q <= drop_cnt_q + `MESH_CNT_W'(drop_q);  // wraps
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept && is_resp)
    begin
      resp_x_o    <= link_i.payload.resp.src_x;
      resp_addr_o <= link_i.payload.resp.addr;
      resp_data_o <= link_i.payload.resp.rdata;
    end
  end

  assign drop_count_o = drop_cnt_q;

  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_x_o)
      && $stable(resp_addr_o) && $stable(resp_data_o))
    else $error("response changed while stalled");

endmodule

//--- mesh_defines.svh
`ifndef MESH_DEFINES_SVH
`define MESH_DEFINES_SVH

`define MESH_TILES  4
`define MESH_X_W    3   // reaches columns past the row
`define MESH_ADDR_W 4   // 16 words per bank
`define MESH_DATA_W 16
`define MESH_CNT_W  8

`endif

//--- mesh_injector.sv
`timescale 1ns/1ns
`include "mesh_defines.svh"

module mesh_injector (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mesh_pkg::mesh_op_e      req_op_i,
  input  logic [`MESH_X_W-1:0]    req_x_i,
  input  logic [`MESH_ADDR_W-1:0] req_addr_i,
  input  logic [`MESH_DATA_W-1:0] req_data_i,
  mesh_link_if.tx                 link_o
);
  import mesh_pkg::*;

  mesh_op_e             op_q [2];
  logic [`MESH_X_W-1:0] x_q  [2];
  mesh_payload_u        pl_q [2];
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;
  logic [1:0]           count_q;
  mesh_payload_u        pl_in;
  logic                 push;
  logic                 pop;

  always_comb
  begin
    pl_in           = '0;
    pl_in.req.addr  = req_addr_i;
    pl_in.req.wdata = req_data_i;
  end

  assign req_ready_o = (count_q != 2'd2); // full blocks even on a pop
  assign push        = req_valid_i && req_ready_o;
  assign pop         = link_o.valid && link_o.ready;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= !wr_ptr_q;
      if (pop)
        rd_ptr_q <= !rd_ptr_q;
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      op_q[wr_ptr_q] <= req_op_i;
      x_q[wr_ptr_q]  <= req_x_i;
      pl_q[wr_ptr_q] <= pl_in;
    end
  end

  assign link_o.valid   = (count_q != 2'd0);
  assign link_o.op      = op_q[rd_ptr_q];
  assign link_o.dest_x  = x_q[rd_ptr_q];
  assign link_o.payload = pl_q[rd_ptr_q];

  // head must not move while stalled
  a_head_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_o.valid && !link_o.ready |=> link_o.valid && $stable(link_o.op)
      && $stable(link_o.dest_x) && $stable(link_o.payload))
    else $error("injector head changed under back-pressure");

endmodule

//--- mesh_link_if.sv
`timescale 1ns/1ns
`include "mesh_defines.svh"

interface mesh_link_if;
  import mesh_pkg::*;

  logic                 valid;
  logic                 ready;
  mesh_op_e             op;
  logic [`MESH_X_W-1:0] dest_x;
  mesh_payload_u        payload;

  // sender side
  modport tx (output valid, output op, output dest_x, output payload, input ready);

  // receiver side
  modport rx (input valid, input op, input dest_x, input payload, output ready);

endinterface

//--- mesh_pkg.sv
`include "mesh_defines.svh"

package mesh_pkg;

  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_RESP  = 2'd2
  } mesh_op_e;

  // same word, view chosen by op
  typedef union packed {
    struct packed {
      logic [`MESH_X_W-1:0]    spare;
      logic [`MESH_ADDR_W-1:0] addr;
      logic [`MESH_DATA_W-1:0] wdata;
    } req;
    struct packed {
      logic [`MESH_X_W-1:0]    src_x;  // responding column
      logic [`MESH_ADDR_W-1:0] addr;   // load address, carried through
      logic [`MESH_DATA_W-1:0] rdata;
    } resp;
  } mesh_payload_u;

endpackage

//--- mesh_row.f
+incdir+.
mesh_pkg.sv
mesh_link_if.sv
mesh_injector.sv
mesh_tile.sv
mesh_collector.sv
mesh_row.sv
tb_mesh_row.sv

//--- mesh_row.sv
`timescale 1ns/1ns
`include "mesh_defines.svh"

module mesh_row (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mesh_pkg::mesh_op_e      req_op_i,
  input  logic [`MESH_X_W-1:0]    req_x_i,
  input  logic [`MESH_ADDR_W-1:0] req_addr_i,
  input  logic [`MESH_DATA_W-1:0] req_data_i,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output logic [`MESH_X_W-1:0]    resp_x_o,
  output logic [`MESH_ADDR_W-1:0] resp_addr_o,
  output logic [`MESH_DATA_W-1:0] resp_data_o,
  output logic [`MESH_CNT_W-1:0]  drop_count_o
);

  // link k feeds tile k, the last one feeds the collector
  mesh_link_if links [`MESH_TILES+1] ();

  mesh_injector u_injector (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_x_i     (req_x_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .link_o      (links[0])
  );

  genvar k;
  for (k = 0; k < `MESH_TILES; k++)
  begin : g_tile
    mesh_tile #(.tile_x_p(k)) u_tile (   // column from position
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .link_i  (links[k]),
      .link_o  (links[k+1])
    );
  end

  mesh_collector u_collector (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_i       (links[`MESH_TILES]),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_x_o     (resp_x_o),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o),
    .drop_count_o (drop_count_o)
  );

endmodule

//--- mesh_tile.sv
`timescale 1ns/1ns
`include "mesh_defines.svh"

module mesh_tile #(
  parameter int tile_x_p = 0
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  mesh_link_if.rx link_i,
  mesh_link_if.tx link_o
);
  import mesh_pkg::*;

  localparam logic [`MESH_X_W-1:0] my_x_lp = `MESH_X_W'(tile_x_p);

  logic [`MESH_DATA_W-1:0] bank_q [2**`MESH_ADDR_W];

  logic                 out_valid_q;
  mesh_op_e             out_op_q;
  logic [`MESH_X_W-1:0] out_x_q;
  mesh_payload_u        out_pl_q;

  logic                 is_local;
  logic                 local_store;
  logic                 accept;
  logic                 out_load;
  mesh_payload_u        resp_pl;

  // responses always pass through
  assign is_local    = (link_i.op != OP_RESP) && (link_i.dest_x == my_x_lp);
  assign local_store = is_local && (link_i.op == OP_STORE);

  // a store never needs the output register
  assign link_i.ready = local_store || !out_valid_q || link_o.ready;
  assign accept       = link_i.valid && link_i.ready;
  assign out_load     = accept && !local_store;

  always_comb
  begin
    resp_pl            = '0;
    resp_pl.resp.src_x = my_x_lp;
    resp_pl.resp.addr  = link_i.payload.req.addr;
    resp_pl.resp.rdata = bank_q[link_i.payload.req.addr];
  end

  // bank starts out all zero
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < 2**`MESH_ADDR_W; i++)
        bank_q[i] <= '0;
    end
    else if (accept && local_store)
    begin
      bank_q[link_i.payload.req.addr] <= link_i.payload.req.wdata;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      out_valid_q <= 1'b0;
    else if (out_load)
      out_valid_q <= 1'b1;
    else if (link_o.ready)
      out_valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (out_load)
    begin
      out_op_q <= is_local ? OP_RESP : link_i.op;  // local load turns around
      out_x_q  <= link_i.dest_x;
      out_pl_q <= is_local ? resp_pl : link_i.payload;
    end
  end

  assign link_o.valid   = out_valid_q;
  assign link_o.op      = out_op_q;
  assign link_o.dest_x  = out_x_q;
  assign link_o.payload = out_pl_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_o.valid && !link_o.ready |=> link_o.valid && $stable(link_o.op)
      && $stable(link_o.dest_x) && $stable(link_o.payload))
    else $error("tile %0d output changed under back-pressure", tile_x_p);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mesh_row -f mesh_row.f -o tb_mesh_row > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_mesh_row > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$sim_log"; then
  exit 1
fi
exit 0

//--- tb_mesh_row.sv
`timescale 1ns/1ns
`include "mesh_defines.svh"

module tb_mesh_row;
  import mesh_pkg::*;

  typedef struct packed {
    logic [`MESH_X_W-1:0]    x;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } resp_t;

  localparam int num_tests_lp      = 5;
  localparam int watchdog_cycles_lp = 200 * num_tests_lp + 100;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  mesh_op_e                req_op_i;
  logic [`MESH_X_W-1:0]    req_x_i;
  logic [`MESH_ADDR_W-1:0] req_addr_i;
  logic [`MESH_DATA_W-1:0] req_data_i;
  logic                    resp_valid_o;
  logic                    resp_ready_i = 1'b1;
  logic [`MESH_X_W-1:0]    resp_x_o;
  logic [`MESH_ADDR_W-1:0] resp_addr_o;
  logic [`MESH_DATA_W-1:0] resp_data_o;
  logic [`MESH_CNT_W-1:0]  drop_count_o;

  logic [`MESH_DATA_W-1:0] model [`MESH_TILES][2**`MESH_ADDR_W];  // expected bank contents
  resp_t       exp_q [$];
  resp_t       got_q [$];
  logic [31:0] rand_state  = 32'd48293;
  logic [31:0] stall_state = 32'd48293 ^ 32'h0000_5a5a;
  logic        stall_en    = 1'b0;
  int          checks      = 0;
  int          errors      = 0;

  mesh_row u_dut (.*);

  always #5 clk_i = !clk_i;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] next_rand();
    rand_state = lcg_step(rand_state);
    return rand_state[31:16];
  endfunction

  always @(posedge clk_i)
  begin
    #1;
    stall_state  = lcg_step(stall_state);
    resp_ready_i = stall_en ? stall_state[20] : 1'b1;  // random stalls when enabled
  end

  // a transfer seen at negedge completes on the next rising edge
  task automatic collect_responses();
    forever
    begin
      @(negedge clk_i);
      if (resp_valid_o && resp_ready_i)
        got_q.push_back({resp_x_o, resp_addr_o, resp_data_o});
    end
  endtask

  task automatic send_req(input mesh_op_e op, input int x, input int addr, input int data);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_x_i     = `MESH_X_W'(x);
    req_addr_i  = `MESH_ADDR_W'(addr);
    req_data_i  = `MESH_DATA_W'(data);
    @(negedge clk_i);
    while (!req_ready_o)
      @(negedge clk_i);
    if (x < `MESH_TILES && op == OP_STORE)
      model[x][addr] = req_data_i;
    if (x < `MESH_TILES && op == OP_LOAD)
      exp_q.push_back({req_x_i, req_addr_i, model[x][addr]});
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic check_responses(input string name, input int errors_before);
    int waited;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < 150)
    begin
      @(negedge clk_i);
      waited++;
    end
    repeat (10) @(negedge clk_i);  // room for any extra response
    checks++;
    if (got_q.size() != exp_q.size())
    begin
      errors++;
      $display("[ERROR] %0t ns: %0d responses arrived, expected %0d", $time,
               got_q.size(), exp_q.size());
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
    begin
      checks++;
      if (got_q[i] != exp_q[i])
      begin
        errors++;
        $display("[ERROR] %0t ns: response %0d is x=%0d addr=%0h data=%0h, expected %0d/%0h/%0h",
                 $time, i, got_q[i].x, got_q[i].addr, got_q[i].data,
                 exp_q[i].x, exp_q[i].addr, exp_q[i].data);
      end
    end
    got_q.delete();
    exp_q.delete();
    $display("test %s finished with %0d errors", name, errors - errors_before);
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_reset_contents();
    int e0;
    e0 = errors;
    for (int t = 0; t < `MESH_TILES; t++)
      for (int a = 0; a < 16; a += 5)
        send_req(OP_LOAD, t, a, 0);
    check_responses("reset_contents", e0);
  endtask

  task automatic test_store_load();
    int e0;
    int a;
    e0 = errors;
    a  = next_rand() % 16;
    send_req(OP_STORE, 2, a, next_rand());
    send_req(OP_LOAD, 2, a, 0);
    check_responses("store_load", e0);
  endtask

  task automatic test_independent_banks();
    int e0;
    int d;
    e0 = errors;
    d  = next_rand();
    for (int t = 0; t < `MESH_TILES; t++)
      send_req(OP_STORE, t, 3, d + t * 16'h1111);  // different word per tile
    for (int t = 0; t < `MESH_TILES; t++)
      send_req(OP_LOAD, t, 3, 0);
    check_responses("independent_banks", e0);
  endtask

  task automatic test_random_stream();
    int       e0;
    mesh_op_e op;
    e0       = errors;
    stall_en = 1'b1;
    repeat (20)
    begin
      op = (next_rand() % 2) ? OP_LOAD : OP_STORE;
      send_req(op, next_rand() % `MESH_TILES, next_rand() % 16, next_rand());
    end
    check_responses("random_stream", e0);
    stall_en = 1'b0;
  endtask

  task automatic test_drops();
    int                     e0;
    int                     a [4];
    int                     waited;
    logic [`MESH_CNT_W-1:0] target;
    e0     = errors;
    target = drop_count_o + `MESH_CNT_W'(8);
    for (int c = 4; c < 8; c++)
    begin
      a[c-4] = next_rand() % 16;
      send_req(OP_STORE, c, a[c-4], next_rand());
      send_req(OP_LOAD, c, a[c-4], 0);
    end
    waited = 0;
    while (drop_count_o != target && waited < 100)
    begin
      @(negedge clk_i);
      waited++;
    end
    repeat (10) @(negedge clk_i);
    checks++;
    if (drop_count_o != target)
    begin
      errors++;
      $display("[ERROR] %0t ns: drop count %0d, expected %0d", $time, drop_count_o, target);
    end
    @(posedge clk_i);
    #1;
    for (int t = 0; t < `MESH_TILES; t++)
      foreach (a[j])
        send_req(OP_LOAD, t, a[j], 0);  // banks must be untouched
    check_responses("drops", e0);
  endtask

  initial
  begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_LOAD;
    req_x_i     = '0;
    req_addr_i  = '0;
    req_data_i  = '0;
    foreach (model[t, a])
      model[t][a] = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    fork
      collect_responses();
    join_none
    @(posedge clk_i);
    #1;
    test_reset_contents();
    test_store_load();
    test_independent_banks();
    test_random_stream();
    test_drops();
    $display("tests: %0d, checks: %0d, errors: %0d", num_tests_lp, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    #(watchdog_cycles_lp * 10);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles_lp);
    $display("Checks failed");
    $finish;
  end

endmodule
